/* sim.f */
verilog/spu_pkg.sv
verilog/spu_word_reduce.sv
verilog/spu_accumulate.sv
verilog/spu_delay.sv
verilog/spu_flag_reduce.sv
verif/tb_spu_flag_reduce.sv

/* verif/spu_flag_vectors.txt */
# columns, all hex: cke s_op s_clear s_valid s_data expected_m_data
# s_op 0 any, 1 all, 2 parity, 3 none; expected is m_data after the cycle's rising edge
# idle, valid low
1 0 0 0 ff 0
1 1 1 0 ff 0
1 2 1 0 01 0
1 0 0 0 80 0
1 3 1 0 ff 0
1 1 0 0 00 0
0 0 1 1 ff 0
1 0 1 0 55 0
1 0 0 0 00 0
# single words with clear
1 0 1 1 00 0
1 3 0 0 00 0
1 0 1 1 ff 0
1 0 1 0 00 0
1 0 1 1 10 1
1 3 0 0 5a 1
1 0 1 1 ef 1
1 1 1 0 ff 1
1 1 1 1 00 1
1 3 0 0 00 1
1 1 1 1 ff 0
1 2 1 0 01 0
1 1 1 1 01 1
1 3 0 0 00 1
1 1 1 1 7f 0
1 0 1 0 ff 0
1 2 1 1 00 0
1 3 0 0 00 0
1 2 1 1 ff 0
1 1 1 0 00 0
1 2 1 1 04 0
1 3 0 0 c3 0
1 2 1 1 fd 1
1 3 0 0 00 1
1 3 0 0 00 1
1 3 0 0 00 1
# runs without clear
1 0 1 1 00 1
1 0 0 1 00 1
1 0 0 1 20 0
1 0 0 1 00 0
1 0 0 1 00 1
1 3 0 0 00 1
1 1 1 1 ff 1
1 1 0 1 ff 1
1 1 0 1 ff 1
1 1 0 1 fe 1
1 1 0 1 ff 1
1 3 0 0 00 0
1 3 0 0 00 0
1 2 1 1 01 0
1 2 0 1 03 0
1 2 0 1 80 1
1 2 0 1 07 1
1 3 0 1 ff 0
1 2 0 1 0e 1
1 3 0 1 00 1
1 3 0 0 00 0
1 3 0 0 00 0
1 1 1 1 ff 0
1 3 0 1 00 0
1 3 0 1 ff 1
1 1 0 1 ff 1
1 3 0 0 00 1
1 3 0 0 00 1
# restart in the middle of a run
1 0 1 1 08 1
1 0 0 1 00 1
1 0 1 1 00 1
1 0 0 1 00 1
1 2 1 1 01 0
1 3 0 0 00 0
1 1 1 1 f0 1
1 3 0 0 00 1
1 3 0 0 00 0
# clock enable stalls
1 0 1 1 02 0
0 0 0 0 00 0
0 1 1 1 00 0
1 3 0 0 00 0
0 3 0 0 00 0
1 3 0 0 00 1
0 1 1 1 00 1
1 1 1 1 ff 1
1 1 0 1 00 1
0 0 1 1 ff 1
0 0 1 1 ff 1
1 2 0 1 01 1
0 2 1 1 00 1
1 3 0 0 00 0
0 3 0 0 00 0
1 3 0 0 00 1
1 3 0 0 00 1
# back to back, mixed opcodes
1 1 1 1 ff 1
1 0 0 1 00 1
1 2 0 1 01 1
1 1 0 1 ff 1
1 0 0 1 40 0
1 2 0 1 03 0
1 2 1 1 10 1
1 1 0 1 fe 1
1 2 0 1 ff 1
1 0 0 1 81 0
1 3 0 0 00 0
1 3 0 0 00 1
1 3 0 0 00 1

/* verif/tb_spu_flag_reduce.sv */
`timescale 1ns/1ps

module tb_spu_flag_reduce;

    localparam string VECTOR_FILE    = "verif/spu_flag_vectors.txt";
    localparam int    VECTOR_FIELDS  = 6;    // cke op clear valid data expected
    localparam int    RESET_CYCLES   = 16;
    localparam int    TIMEOUT_MARGIN = 20;

    // ------------------------------------------------------------------------
    //  DUT signals
    // ------------------------------------------------------------------------

    logic               reset;
    logic               clk;
    logic               cke;
    spu_pkg::data_t     s_data;
    spu_pkg::op_t       s_op;
    logic               s_clear;
    logic               s_valid;
    logic               m_data;

    spu_flag_reduce spu_flag_reduce_i (
        .reset      (reset),
        .clk        (clk),
        .cke        (cke),
        .s_data     (s_data),
        .s_op       (s_op),
        .s_clear    (s_clear),
        .s_valid    (s_valid),
        .m_data     (m_data)
    );

    // ------------------------------------------------------------------------
    //  vector storage and counters
    // ------------------------------------------------------------------------

    logic               vec_cke[$];
    logic   [1:0]       vec_op[$];
    logic               vec_clear[$];
    logic               vec_valid[$];
    spu_pkg::data_t     vec_data[$];
    logic               vec_exp[$];
    int                 vec_line[$];    // file line, for error lines

    bit     load_ok        = 1'b1;
    int     check_count    = 0;
    int     mismatch_count = 0;
    int     other_errors   = 0;
    int     cycle_count    = 0;
    int     cycle_limit    = RESET_CYCLES + spu_pkg::LATENCY + TIMEOUT_MARGIN;

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // ------------------------------------------------------------------------
    //  vector file reader
    // ------------------------------------------------------------------------

    // blank lines and # comments carry no vector
    function automatic bit is_skip_line(input string text);
        int  k;
        byte ch;
        for (k = 0; k < text.len(); k++) begin
            ch = text[k];
            if (ch == "#") begin
                return 1'b1;
            end
            if (ch != " " && ch != "\t" && ch != "\n" && ch != "\r") begin
                return 1'b0;
            end
        end
        return 1'b1;
    endfunction

    task automatic load_vectors();
        int    fd;
        int    line_no;
        int    count;
        int    f_cke;
        int    f_op;
        int    f_clear;
        int    f_valid;
        int    f_data;
        int    f_exp;
        string text;
        fd = $fopen(VECTOR_FILE, "r");
        if (fd == 0) begin
            $display("error: cannot open vector file %s", VECTOR_FILE);
            other_errors++;
            load_ok = 1'b0;
            return;
        end
        line_no = 0;
        while (load_ok && !$feof(fd)) begin
            text = "";
            count = $fgets(text, fd);
            line_no++;
            if (!is_skip_line(text)) begin
                count = $sscanf(text, "%h %h %h %h %h %h",
                                f_cke, f_op, f_clear, f_valid, f_data, f_exp);
                if (count != VECTOR_FIELDS || f_cke > 1 || f_op > 3 || f_clear > 1
                        || f_valid > 1 || f_data > 255 || f_exp > 1) begin
                    $display("error: malformed vector on line %0d of %s",
                             line_no, VECTOR_FILE);
                    other_errors++;
                    load_ok = 1'b0;
                end else begin
                    vec_cke.push_back(f_cke[0]);
                    vec_op.push_back(f_op[1:0]);
                    vec_clear.push_back(f_clear[0]);
                    vec_valid.push_back(f_valid[0]);
                    vec_data.push_back(f_data[7:0]);
                    vec_exp.push_back(f_exp[0]);
                    vec_line.push_back(line_no);
                end
            end
        end
        $fclose(fd);
        if (load_ok && vec_exp.size() == 0) begin
            $display("error: no vectors found in %s", VECTOR_FILE);
            other_errors++;
            load_ok = 1'b0;
        end
    endtask

    // ------------------------------------------------------------------------
    //  drive and check
    // ------------------------------------------------------------------------

    task automatic hold_reset();
        repeat (RESET_CYCLES) begin
            @(negedge clk);
            check_count++;
            if (m_data !== 1'b0) begin
                $display("FAIL %0t: m_data is %b during reset, expected 0", $time, m_data);
                mismatch_count++;
            end
        end
        reset = 1'b0;   // same falling edge as the first vector
    endtask

    task automatic drive_vector(input int idx);
        cke     = vec_cke[idx];
        s_op    = spu_pkg::op_t'(vec_op[idx]);
        s_clear = vec_clear[idx];
        s_valid = vec_valid[idx];
        s_data  = vec_data[idx];
    endtask

    task automatic check_output(input int idx);
        check_count++;
        if (m_data !== vec_exp[idx]) begin
            $display("FAIL %0t: line %0d expected m_data %0h, got %0h",
                     $time, vec_line[idx], vec_exp[idx], m_data);
            mismatch_count++;
        end
    endtask

    task automatic run_vectors();
        int i;
        for (i = 0; i < vec_exp.size(); i++) begin
            drive_vector(i);
            @(negedge clk);     // rising edge of this cycle has passed
            check_output(i);
        end
    endtask

    // ------------------------------------------------------------------------
    //  main sequence
    // ------------------------------------------------------------------------

    initial begin
        reset   = 1'b1;
        cke     = 1'b1;
        s_data  = '0;
        s_op    = spu_pkg::OP_ANY;   // w_flag settles to 0 during reset
        s_clear = 1'b0;
        s_valid = 1'b0;
        load_vectors();
        if (load_ok) begin
            cycle_limit = RESET_CYCLES + vec_exp.size() + spu_pkg::LATENCY
                          + TIMEOUT_MARGIN;
            hold_reset();
            run_vectors();
        end
        $display("summary: %0d checks, %0d mismatches, %0d other errors",
                 check_count, mismatch_count, other_errors);
        if (mismatch_count == 0 && other_errors == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

    // watchdog on rising edges
    initial begin
        while (cycle_count < cycle_limit) begin
            @(posedge clk);
            cycle_count++;
        end
        other_errors++;
        $display("error: timeout, test still running after %0d clock cycles", cycle_count);
        $display("summary: %0d checks, %0d mismatches, %0d other errors",
                 check_count, mismatch_count, other_errors);
        $display("Done: errors found");
        $finish;
    end

endmodule

/* verilog/spu_accumulate.sv */
`timescale 1ns/1ps
`default_nettype none

module spu_accumulate (
        input   var logic               reset,
        input   var logic               clk,
        input   var logic               cke,

        input   var logic               w_flag,
        input   var spu_pkg::op_t       w_op,
        input   var logic               w_clear,
        input   var logic               w_valid,

        output  var logic               a_flag
    );

    // ------------------------------------------------------------------------
    //  combine
    // ------------------------------------------------------------------------

    // each word carries its own opcode, so a run may mix operations
    logic   combined;

    always_comb begin
        case (w_op)
            spu_pkg::OP_ANY: begin
                combined = a_flag | w_flag;     // sticks at 1
            end
            spu_pkg::OP_ALL: begin
                combined = a_flag & w_flag;     // sticks at 0
            end
            spu_pkg::OP_PARITY: begin
                combined = a_flag ^ w_flag;
            end
            spu_pkg::OP_NONE: begin
                combined = a_flag;
            end
            default: begin
                combined = a_flag;
            end
        endcase
    end

    // ------------------------------------------------------------------------
    //  running flag
    // ------------------------------------------------------------------------

    logic   next_flag;

    // clear restarts the run from this word alone
    assign next_flag = w_clear ? w_flag : combined;

    always_ff @(posedge clk) begin
        if (reset) begin
            a_flag <= 1'b0;
        end else if (cke) begin
            if (w_valid) begin
                a_flag <= next_flag;
            end
        end
    end

endmodule

`default_nettype wire

/* verilog/spu_delay.sv */
`timescale 1ns/1ps
`default_nettype none

module spu_delay (
        input   var logic   reset,
        input   var logic   clk,
        input   var logic   cke,

        input   var logic   a_flag,

        output  var logic   m_data
    );

    // ------------------------------------------------------------------------
    //  shift chain
    // ------------------------------------------------------------------------

    // stage[0] takes the accumulator output, the last stage is m_data
    logic   [spu_pkg::DELAY_STAGES-1:0]  stage;

    always_ff @(posedge clk) begin
        if (reset) begin
            stage <= '0;
        end else if (cke) begin
            stage[0] <= a_flag;
            for (int i = 1; i < spu_pkg::DELAY_STAGES; i++) begin
                stage[i] <= stage[i-1];
            end
        end
    end

    // ------------------------------------------------------------------------
    //  output
    // ------------------------------------------------------------------------

    assign m_data = stage[spu_pkg::DELAY_STAGES-1];

endmodule

`default_nettype wire

/* verilog/spu_flag_reduce.sv */
`timescale 1ns/1ps
`default_nettype none

module spu_flag_reduce (
        input   var logic               reset,
        input   var logic               clk,
        input   var logic               cke,

        input   var spu_pkg::data_t     s_data,
        input   var spu_pkg::op_t       s_op,
        input   var logic               s_clear,
        input   var logic               s_valid,

        output  var logic               m_data
    );

    // ------------------------------------------------------------------------
    //  stage 1 : word reduce
    // ------------------------------------------------------------------------

    logic               w_flag;
    spu_pkg::op_t       w_op;
    logic               w_clear;
    logic               w_valid;

    spu_word_reduce spu_word_reduce_i (
        .reset      (reset),
        .clk        (clk),
        .cke        (cke),
        .s_data     (s_data),
        .s_op       (s_op),
        .s_clear    (s_clear),
        .s_valid    (s_valid),
        .w_flag     (w_flag),
        .w_op       (w_op),
        .w_clear    (w_clear),
        .w_valid    (w_valid)
    );

    // ------------------------------------------------------------------------
    //  stage 2 : accumulate
    // ------------------------------------------------------------------------

    logic               a_flag;

    spu_accumulate spu_accumulate_i (
        .reset      (reset),
        .clk        (clk),
        .cke        (cke),
        .w_flag     (w_flag),
        .w_op       (w_op),
        .w_clear    (w_clear),
        .w_valid    (w_valid),
        .a_flag     (a_flag)
    );

    // ------------------------------------------------------------------------
    //  latency padding
    // ------------------------------------------------------------------------

    spu_delay spu_delay_i (
        .reset      (reset),
        .clk        (clk),
        .cke        (cke),
        .a_flag     (a_flag),
        .m_data     (m_data)    // spu_pkg::LATENCY after sample
    );

endmodule

`default_nettype wire

/* verilog/spu_pkg.sv */
package spu_pkg;

    // ------------------------------------------------------------------------
    //  data path
    // ------------------------------------------------------------------------

    localparam int DATA_BITS = 8;   // width of s_data

    typedef logic [DATA_BITS-1:0] data_t;

    // ------------------------------------------------------------------------
    //  reduction opcodes
    // ------------------------------------------------------------------------

    // each opcode selects both the word reduction and the run combine
    typedef enum logic [1:0] {
        OP_ANY    = 2'd0,   // OR reduce, OR combine
        OP_ALL    = 2'd1,   // AND reduce, AND combine
        OP_PARITY = 2'd2,   // XOR reduce, XOR combine
        OP_NONE   = 2'd3    // flag 0, running flag untouched
    } op_t;

    // ------------------------------------------------------------------------
    //  latency
    // ------------------------------------------------------------------------

    // extra flops after the accumulator so this lane lines up with
    // the arithmetic lanes of the unit
    localparam int DELAY_STAGES = 1;

    // reduce stage + accumulate stage + delay chain
    localparam int LATENCY = 2 + DELAY_STAGES;

endpackage

/* verilog/spu_word_reduce.sv */
`timescale 1ns/1ps
`default_nettype none

module spu_word_reduce (
        input   var logic               reset,
        input   var logic               clk,
        input   var logic               cke,

        input   var spu_pkg::data_t     s_data,
        input   var spu_pkg::op_t       s_op,
        input   var logic               s_clear,
        input   var logic               s_valid,

        output  var logic               w_flag,
        output  var spu_pkg::op_t       w_op,
        output  var logic               w_clear,
        output  var logic               w_valid
    );

    // ------------------------------------------------------------------------
    //  word to flag
    // ------------------------------------------------------------------------

    logic   word_flag;

    always_comb begin
        case (s_op)
            spu_pkg::OP_ANY:    word_flag = |s_data;
            spu_pkg::OP_ALL:    word_flag = &s_data;
            spu_pkg::OP_PARITY: word_flag = ^s_data;   // odd parity
            spu_pkg::OP_NONE:   word_flag = 1'b0;
            default:            word_flag = 1'b0;
        endcase
    end

    // ------------------------------------------------------------------------
    //  stage register
    // ------------------------------------------------------------------------

    // opcode and strobes of the sampled word
    always_ff @(posedge clk) begin
        if (reset) begin
            w_op    <= spu_pkg::OP_NONE;
            w_clear <= 1'b0;
            w_valid <= 1'b0;
        end else if (cke) begin
            w_op    <= s_op;
            w_clear <= s_clear;
            w_valid <= s_valid;
        end
    end

    // reduced flag of the sampled word
    always_ff @(posedge clk) begin
        if (cke) begin
            w_flag <= word_flag;
        end
    end

endmodule

`default_nettype wire
